// ==== dlc_top.f ====
+incdir+include
rtl/dlc_pkg.sv
rtl/lc_event_if.sv
rtl/dlc_fifo.sv
rtl/dlc_level_detector.sv
rtl/dlc_event_encoder.sv
rtl/dlc_top.sv
tb/tb_dlc_top.sv

// ==== Makefile ====
TOP = tb_dlc_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dlc_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb/tb_dlc_top.sv ====
// table-driven testbench for dlc_top, runs each config row against a packet model with back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_dlc_top import dlc_pkg::*; ();

  localparam int N_ROWS = 6;
  localparam int N_SMP  = 12;                                   // samples per row
  localparam int unsigned WDOG_NS = N_ROWS * N_SMP * 200 * 8;   // 200 cycles per sample

  logic    clk_i = 1'b0;
  logic    rst_ni;
  logic    in_push_i;
  sample_t in_data_i;
  logic    in_full_o;
  logic    out_pop_i;
  packet_t out_data_o;
  logic    out_empty_o;
  shift_t  lvl_shift_i;
  shift_t  dlvl_bits_i;
  shift_t  dt_bits_i;
  logic    twos_comp_i;

  // test table
  shift_t  cfg_shift [N_ROWS];
  shift_t  cfg_dbits [N_ROWS];
  shift_t  cfg_tbits [N_ROWS];
  logic    cfg_tc    [N_ROWS];
  int      cfg_nfix  [N_ROWS];   // leading fixed samples, rest random
  sample_t smp       [N_ROWS][N_SMP];

  packet_t     exp_q[$];         // model output still to be seen
  int          seed;
  int          n_errors;
  int          n_checks;
  logic        drain_en;         // output side may pop
  logic [31:0] stall;

  dlc_top dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_push_i   (in_push_i),
    .in_data_i   (in_data_i),
    .in_full_o   (in_full_o),
    .out_pop_i   (out_pop_i),
    .out_data_o  (out_data_o),
    .out_empty_o (out_empty_o),
    .lvl_shift_i (lvl_shift_i),
    .dlvl_bits_i (dlvl_bits_i),
    .dt_bits_i   (dt_bits_i),
    .twos_comp_i (twos_comp_i)
  );

  always #4 clk_i = ~clk_i;  // 8 ns period

  task automatic check_value(input packet_t expected, input packet_t actual, input string what);
    n_checks++;
    if (expected !== actual) begin
      $display("Error at %0t ns: %s expected %h got %h", $time, what, expected, actual);
      n_errors++;
    end
  endtask

  function automatic dtime_t low_ones(input shift_t n);
    return ~(16'hffff << n);
  endfunction

  // packet word from dt, sign and magnitude, per the row format
  function automatic packet_t pack_packet(input int r, input dtime_t dt, input logic neg,
                                          input dtime_t mag);
    logic [31:0] wide;
    dtime_t      m;
    dtime_t      delta;
    m = low_ones(cfg_dbits[r]);
    if (cfg_tc[r]) begin
      delta = neg ? (16'd0 - mag) : mag;
      wide  = ({16'd0, dt} << cfg_dbits[r]) | {16'd0, delta & m};
    end else begin
      wide = ({15'd0, dt, neg} << cfg_dbits[r]) | {16'd0, mag & m};  // dir just above field
    end
    return wide[15:0];
  endfunction

  // expected packet stream of one row
  function automatic void model_row(input int r);
    dtime_t t;
    dtime_t l;
    dtime_t skip;
    dtime_t dt;
    dtime_t mag;
    level_t cur;
    level_t lvl;
    level_t d;
    logic   neg;
    int     i;
    t    = low_ones(cfg_tbits[r]);
    l    = cfg_tc[r] ? (low_ones(cfg_dbits[r]) >> 1) : low_ones(cfg_dbits[r]);
    cur  = '0;
    skip = 16'd1;
    for (i = 0; i < N_SMP; i++) begin
      lvl = smp[r][i] >>> cfg_shift[r];
      d   = lvl - cur;
      if (d != '0) begin
        cur = lvl;
        neg = d[15];
        mag = neg ? dtime_t'(-d) : dtime_t'(d);
        dt  = skip;
        while (mag > l) begin                    // oversized step, chunks of L
          exp_q.push_back(pack_packet(r, dt, neg, l));
          dt  = '0;
          mag = mag - l;
        end
        exp_q.push_back(pack_packet(r, dt, neg, mag));
        skip = 16'd1;
      end else if (skip == t) begin
        exp_q.push_back(pack_packet(r, t, 1'b0, '0));  // filler
        skip = 16'd1;
      end else begin
        skip = skip + 16'd1;
      end
    end
  endfunction

  task automatic set_row(input int r, input shift_t sh, input shift_t db, input shift_t tb,
                         input logic tc, input int nfix);
    cfg_shift[r] = sh;
    cfg_dbits[r] = db;
    cfg_tbits[r] = tb;
    cfg_tc[r]    = tc;
    cfg_nfix[r]  = nfix;
  endtask

  task automatic build_table();
    int r;
    int i;
    set_row(0, 4'd2, 4'd4, 4'd4, 1'b1, 12);  // small steps, two's complement
    set_row(1, 4'd2, 4'd4, 4'd4, 1'b0, 12);  // same stream, sign-magnitude
    set_row(2, 4'd2, 4'd4, 4'd2, 1'b1, 12);  // long flat run, T = 3
    set_row(3, 4'd0, 4'd3, 4'd4, 1'b1, 5);   // L = 3, big jumps
    set_row(4, 4'd0, 4'd3, 4'd3, 1'b0, 4);   // L = 7, big jumps
    set_row(5, 4'd2, 4'd5, 4'd3, 1'b1, 0);   // all random, back-pressure
    smp[0] = '{16'sd4, 16'sd8, 16'sd9, 16'sd8, 16'sd0, -16'sd4,
               -16'sd5, -16'sd8, 16'sd0, 16'sd3, 16'sd4, 16'sd12};
    smp[1] = smp[0];
    smp[2] = '{16'sd1, 16'sd2, 16'sd3, 16'sd0, 16'sd1, 16'sd2,
               16'sd3, 16'sd1, 16'sd0, 16'sd2, 16'sd20, 16'sd21};
    smp[3] = '{16'sd0, 16'sd40, 16'sd40, -16'sd12, 16'sd3, 16'sd0,
               16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0};
    smp[4] = '{16'sd0, -16'sd30, 16'sd30, 16'sd1, 16'sd0, 16'sd0,
               16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0};
    for (r = 0; r < N_ROWS; r++) begin
      for (i = cfg_nfix[r]; i < N_SMP; i++) begin
        smp[r][i] = sample_t'($random(seed) % 64);  // kept small, bounds split length
      end
    end
  endtask

  task automatic reset_dut(input int r);
    @(posedge clk_i);
    #1;
    rst_ni      = 1'b0;
    in_push_i   = 1'b0;
    lvl_shift_i = cfg_shift[r];  // config settles during reset
    dlvl_bits_i = cfg_dbits[r];
    dt_bits_i   = cfg_tbits[r];
    twos_comp_i = cfg_tc[r];
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_value(packet_t'(1'b1), packet_t'(out_empty_o), "out_empty_o after reset");
    check_value(packet_t'(1'b0), packet_t'(in_full_o), "in_full_o after reset");
  endtask

  // push as fast as in_full_o allows
  task automatic push_samples(input int r);
    int i;
    i = 0;
    while (i < N_SMP) begin
      @(posedge clk_i);
      #1;
      in_push_i = 1'b0;
      if (!in_full_o) begin
        in_push_i = 1'b1;
        in_data_i = smp[r][i];
        i++;
      end
    end
    @(posedge clk_i);
    #1;
    in_push_i = 1'b0;
  endtask

  // output side, pops about half the cycles
  always begin
    @(posedge clk_i);
    #1;
    out_pop_i = 1'b0;
    stall     = $random(seed);
    if (drain_en && !out_empty_o && stall[0]) begin
      out_pop_i = 1'b1;
      if (exp_q.size() == 0) begin
        $display("unexpected packet %h at %0t ns, the model expects no more", out_data_o, $time);
        n_errors++;
      end else begin
        check_value(exp_q.pop_front(), out_data_o, "packet");
      end
    end
  end

  initial begin
    #(WDOG_NS);
    $display("timeout: run did not finish within %0d ns", WDOG_NS);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int r;
    seed        = 49299;
    n_errors    = 0;
    n_checks    = 0;
    drain_en    = 1'b0;
    rst_ni      = 1'b0;
    in_push_i   = 1'b0;
    in_data_i   = '0;
    out_pop_i   = 1'b0;
    lvl_shift_i = '0;
    dlvl_bits_i = '0;
    dt_bits_i   = '0;
    twos_comp_i = 1'b0;
    build_table();
    for (r = 0; r < N_ROWS; r++) begin
      reset_dut(r);
      model_row(r);
      @(negedge clk_i);
      drain_en = 1'b1;  // switched away from the popper's sample point
      push_samples(r);
      while (exp_q.size() != 0) @(posedge clk_i);
      repeat (20) @(posedge clk_i);  // catch extra packets
      @(negedge clk_i);
      drain_en = 1'b0;
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/dlc_top.sv ====
// top level of the level-crossing encoder, chains input FIFO, detector, encoder and output FIFO
`timescale 1ns/1ps
`default_nettype none

`include "dlc_params.svh"

module dlc_top import dlc_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  // sample side
  input  wire logic    in_push_i,
  input  wire sample_t in_data_i,
  output logic         in_full_o,
  // packet side
  input  wire logic    out_pop_i,
  output packet_t      out_data_o,
  output logic         out_empty_o,
  // static config, hold while samples are in flight
  input  wire shift_t  lvl_shift_i,
  input  wire shift_t  dlvl_bits_i,
  input  wire shift_t  dt_bits_i,
  input  wire logic    twos_comp_i
);

  logic    in_empty;
  logic    in_pop;
  sample_t in_head;
  logic    out_full;
  logic    out_push;
  packet_t enc_data;

  lc_event_if ev_if ();

  dlc_fifo #(.DEPTH(`DLC_FIFO_DEPTH)) u_in_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (in_push_i),
    .data_i  (in_data_i),
    .full_o  (in_full_o),
    .pop_i   (in_pop),
    .data_o  (in_head),
    .empty_o (in_empty)
  );

  dlc_level_detector u_detector (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fifo_empty_i (in_empty),
    .fifo_data_i  (in_head),
    .fifo_pop_o   (in_pop),
    .lvl_shift_i  (lvl_shift_i),
    .ev           (ev_if.detector)
  );

  dlc_event_encoder u_encoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ev          (ev_if.encoder),
    .dlvl_bits_i (dlvl_bits_i),
    .dt_bits_i   (dt_bits_i),
    .twos_comp_i (twos_comp_i),
    .out_full_i  (out_full),
    .out_push_o  (out_push),
    .out_data_o  (enc_data)
  );

  // packets reuse the sample-wide FIFO
  dlc_fifo #(.DEPTH(`DLC_FIFO_DEPTH)) u_out_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (out_push),
    .data_i  (enc_data),
    .full_o  (out_full),
    .pop_i   (out_pop_i),
    .data_o  (out_data_o),
    .empty_o (out_empty_o)
  );

endmodule

`default_nettype wire

// ==== rtl/dlc_event_encoder.sv ====
// event encoder stage, turns crossings into dt/dlvl packets and handles dt and dlvl overflow
`timescale 1ns/1ps
`default_nettype none

`include "dlc_params.svh"

module dlc_event_encoder import dlc_pkg::*; (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  lc_event_if.encoder ev,
  input  wire shift_t dlvl_bits_i,  // width of the delta-level field
  input  wire shift_t dt_bits_i,    // width of the delta-time field
  input  wire logic   twos_comp_i,  // 1 two's complement, 0 sign-magnitude
  input  wire logic   out_full_i,
  output logic        out_push_o,
  output packet_t     out_data_o
);

  localparam int unsigned MSB = `DLC_DATA_W - 1;

  enc_state_t state_q, state_d;
  dtime_t     skip_q, skip_d;  // samples since the last packet
  dtime_t     rem_q, rem_d;    // magnitude still to send in a split
  logic       dir_q, dir_d;    // sign kept across a split

  dtime_t     dlvl_mask;       // M
  dtime_t     dt_mask;         // T
  dtime_t     lim;             // L, largest magnitude per packet
  dtime_t     dlvl_abs;

  logic       have_pkt;
  dtime_t     pkt_dt;
  dtime_t     pkt_mag;
  logic       pkt_dir;         // 1 for a downward step
  level_t     pkt_delta;
  logic [`DLC_DATA_W:0] dt_dir;     // {dt, dir} for sign-magnitude
  logic [`DLC_DATA_W:0] dt_dir_sh;

  // field masks from bit counts
  assign dlvl_mask = ~({`DLC_DATA_W{1'b1}} << dlvl_bits_i);
  assign dt_mask   = ~({`DLC_DATA_W{1'b1}} << dt_bits_i);
  assign lim       = twos_comp_i ? (dlvl_mask >> 1) : dlvl_mask;  // sign bit eats one in TC

  assign dlvl_abs = ev.dlvl[MSB] ? dtime_t'(-ev.dlvl) : dtime_t'(ev.dlvl);

  always_comb begin
    state_d  = state_q;
    skip_d   = skip_q;
    rem_d    = rem_q;
    dir_d    = dir_q;
    have_pkt = 1'b0;
    pkt_dt   = '0;
    pkt_mag  = '0;
    pkt_dir  = 1'b0;
    ev.take  = 1'b0;
    unique case (state_q)
      ENC_RUN: begin
        if (ev.valid && !out_full_i) begin  // stall whole stage on full
          ev.take = 1'b1;
          if (ev.xing) begin
            have_pkt = 1'b1;
            pkt_dt   = skip_q;
            pkt_dir  = ev.dlvl[MSB];
            if (dlvl_abs <= lim) begin
              pkt_mag = dlvl_abs;
              skip_d  = dtime_t'(1);
            end else begin                  // too big, first chunk now
              pkt_mag = lim;
              rem_d   = dlvl_abs - lim;
              dir_d   = ev.dlvl[MSB];
              state_d = ENC_DLVL_SPLIT;
            end
          end else if (skip_q == dt_mask) begin
            state_d = ENC_DT_FILL;          // dt field saturated
          end else begin
            skip_d = skip_q + 1'b1;
          end
        end
      end
      ENC_DLVL_SPLIT: begin
        have_pkt = 1'b1;                    // dt stays 0 here
        pkt_dir  = dir_q;
        if (rem_q <= lim) begin             // last chunk
          pkt_mag = rem_q;
          if (!out_full_i) begin
            state_d = ENC_RUN;
            skip_d  = dtime_t'(1);
          end
        end else begin
          pkt_mag = lim;
          if (!out_full_i) rem_d = rem_q - lim;
        end
      end
      ENC_DT_FILL: begin
        have_pkt = 1'b1;
        pkt_dt   = dt_mask;                 // filler, delta 0
        if (!out_full_i) begin
          state_d = ENC_RUN;
          skip_d  = dtime_t'(1);
        end
      end
      default: state_d = ENC_RUN;
    endcase
  end

  // packing
  assign pkt_delta = pkt_dir ? -level_t'(pkt_mag) : level_t'(pkt_mag);
  assign dt_dir    = {pkt_dt, pkt_dir};
  assign dt_dir_sh = dt_dir << dlvl_bits_i;  // 17 bits, top bit dropped below

  always_comb begin
    if (twos_comp_i) begin
      out_data_o = packet_t'(pkt_dt << dlvl_bits_i) | (packet_t'(pkt_delta) & dlvl_mask);
    end else begin
      out_data_o = dt_dir_sh[`DLC_DATA_W-1:0] | (pkt_mag & dlvl_mask);
    end
  end

  assign out_push_o = have_pkt && !out_full_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ENC_RUN;
      skip_q  <= dtime_t'(1);  // first packet counts from 1
    end else begin
      state_q <= state_d;
      skip_q  <= skip_d;
    end
  end

  // split payload
  always_ff @(posedge clk_i) begin
    rem_q <= rem_d;
    dir_q <= dir_d;
  end

  // detector must hold an event until it is taken
  a_event_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ev.valid && !ev.take |=> ev.valid && $stable(ev.dlvl) && $stable(ev.xing))
    else $error("dlc_event_encoder: pending event changed");

  // a split always has magnitude left to send
  a_split_rem: assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q == ENC_DLVL_SPLIT |-> rem_q != '0)
    else $error("dlc_event_encoder: empty split remainder");

endmodule

`default_nettype wire

// ==== rtl/dlc_level_detector.sv ====
// level detector stage, pops samples, quantizes them and registers one crossing event per sample
`timescale 1ns/1ps
`default_nettype none

`include "dlc_params.svh"

module dlc_level_detector import dlc_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    fifo_empty_i,
  input  wire sample_t fifo_data_i,
  output logic         fifo_pop_o,
  input  wire shift_t  lvl_shift_i,
  lc_event_if.detector ev
);

  level_t cur_lvl_q;  // level of the last crossing
  level_t din_lvl;    // level of the head sample
  level_t dlvl;       // distance from the current level
  logic   valid_q;
  logic   xing_q;
  level_t dlvl_q;

  // quantize by arithmetic shift, window width is 2**lvl_shift_i
  assign din_lvl = fifo_data_i >>> lvl_shift_i;
  assign dlvl    = din_lvl - cur_lvl_q;

  // room when empty or the held event leaves this cycle
  assign fifo_pop_o = !fifo_empty_i && (!valid_q || ev.take);

  assign ev.valid = valid_q;
  assign ev.xing  = xing_q;
  assign ev.dlvl  = dlvl_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      cur_lvl_q <= '0;
    end else begin
      if (fifo_pop_o) begin
        valid_q <= 1'b1;                            // reload, even on a take
        if (dlvl != '0) cur_lvl_q <= din_lvl;       // follow the crossing at once
      end else if (ev.take) begin
        valid_q <= 1'b0;
      end
    end
  end

  // event payload
  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      xing_q <= (dlvl != '0);
      dlvl_q <= dlvl;
    end
  end

  // consumer may only take a held event
  a_take_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ev.take |-> valid_q)
    else $error("dlc_level_detector: take without a held event");

endmodule

`default_nettype wire

// ==== rtl/dlc_fifo.sv ====
// synchronous FIFO with registered head, used for both the sample and the packet buffer
`timescale 1ns/1ps
`default_nettype none

`include "dlc_params.svh"

module dlc_fifo import dlc_pkg::*; #(
  parameter int unsigned DEPTH = `DLC_FIFO_DEPTH  // at least 2
) (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    push_i,
  input  wire sample_t data_i,
  output logic         full_o,
  input  wire logic    pop_i,
  output sample_t      data_o,
  output logic         empty_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  sample_t            mem [DEPTH];  // storage, no reset
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   cnt_q;        // entries held

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem[rd_ptr_q];   // head visible the cycle after its push

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;  // wrap
      if (pop_i) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // both or neither, occupancy unchanged
      endcase
    end
  end

  // writer must honour full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("dlc_fifo: push while full");

  // reader must honour empty
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("dlc_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== rtl/lc_event_if.sv ====
// detector-to-encoder event link, one registered sample with a take strobe
`timescale 1ns/1ps
`default_nettype none

interface lc_event_if import dlc_pkg::*; ();

  logic   valid;  // event register holds a sample
  logic   xing;   // sample crossed into a new level
  level_t dlvl;   // new level minus old level
  logic   take;   // encoder consumes the event this cycle

  // event producer
  modport detector (
    output valid, xing, dlvl,
    input  take
  );

  // event consumer
  modport encoder (
    input  valid, xing, dlvl,
    output take
  );

endinterface

`default_nettype wire

// ==== rtl/dlc_pkg.sv ====
// shared types of the level-crossing encoder, imported by the interface and every RTL module
`default_nettype none

`include "dlc_params.svh"

package dlc_pkg;

  // raw input sample, signed
  typedef logic signed [`DLC_DATA_W-1:0] sample_t;

  // quantized level or level difference
  typedef logic signed [`DLC_DATA_W-1:0] level_t;

  // skip count / delta time, always positive
  typedef logic [`DLC_DATA_W-1:0] dtime_t;

  typedef logic [`DLC_DATA_W-1:0] packet_t;  // one encoded output word

  typedef logic [`DLC_SHIFT_W-1:0] shift_t;  // shift amount or field bit count

  // encoder FSM
  typedef enum logic [1:0] {
    ENC_RUN,         // normal event handling
    ENC_DLVL_SPLIT,  // emitting the rest of an oversized delta level
    ENC_DT_FILL      // emitting a filler for a saturated skip count
  } enc_state_t;

endpackage

`default_nettype wire

// ==== include/dlc_params.svh ====
// width and depth macros for the level-crossing encoder, included by the package and the RTL
`ifndef DLC_PARAMS_SVH
`define DLC_PARAMS_SVH

// sample, level, time counter and packet width
`define DLC_DATA_W 16

// shift amount and bit-count field width
`define DLC_SHIFT_W 4

// default depth of the input and output FIFOs
`define DLC_FIFO_DEPTH 4

`endif
